/* rtl/avr_io_pkg.sv */
// AVR I/O subsystem package.
// Holds the bus types, the I/O register map, the register field
// positions and the prescaler taps shared by all peripheral blocks.

`default_nettype none

package avr_io_pkg;

	// Bus and register types.
	typedef logic [5:0] io_addr_t;
	typedef logic [7:0] io_data_t;
	typedef logic [7:0] pins_t;
	typedef logic [7:0] tmr_count_t;
	typedef logic [2:0] clk_sel_t;

	// Register offset inside a GPIO port, in address order.
	typedef enum logic [1:0]
	{
		GPIO_PIN  = 2'd0,
		GPIO_DDR  = 2'd1,
		GPIO_PORT = 2'd2
	} gpio_reg_t;

	// Timer 0 register select.
	typedef enum logic [2:0]
	{
		TMR_TIFR  = 3'd0,
		TMR_TCCRA = 3'd1,
		TMR_TCCRB = 3'd2,
		TMR_TCNT  = 3'd3,
		TMR_OCRA  = 3'd4,
		TMR_OCRB  = 3'd5
	} tmr_reg_t;

	// I/O space addresses.
	localparam io_addr_t PINB_ADDR   = 6'h03;
	localparam io_addr_t DDRB_ADDR   = 6'h04;
	localparam io_addr_t PORTB_ADDR  = 6'h05;
	localparam io_addr_t PIND_ADDR   = 6'h09;
	localparam io_addr_t DDRD_ADDR   = 6'h0A;
	localparam io_addr_t PORTD_ADDR  = 6'h0B;
	localparam io_addr_t TIFR0_ADDR  = 6'h15;
	localparam io_addr_t TCCR0A_ADDR = 6'h24;
	localparam io_addr_t TCCR0B_ADDR = 6'h25;
	localparam io_addr_t TCNT0_ADDR  = 6'h26;
	localparam io_addr_t OCR0A_ADDR  = 6'h27;
	localparam io_addr_t OCR0B_ADDR  = 6'h28;

	// Implemented pins per port and the compare output pins.
	localparam pins_t PORTB_PIN_MASK = 8'b1111_0000;
	localparam pins_t PORTD_PIN_MASK = 8'b1111_1111;
	localparam int    OC0A_PIN       = 7;
	localparam int    OC0B_PIN       = 0;

	// TIFR0 flag bits.
	localparam int TOV0_BIT  = 0;
	localparam int OCF0A_BIT = 1;
	localparam int OCF0B_BIT = 2;

	// TCCR0A compare output fields.
	localparam int         COM0A_LSB  = 6;
	localparam int         COM0B_LSB  = 4;
	localparam logic [1:0] COM_TOGGLE = 2'b01;

	// Prescaler width and tap bits.
	localparam int PRESC_WIDTH    = 10;
	localparam int PRESC_TAP_8    = 2;
	localparam int PRESC_TAP_64   = 5;
	localparam int PRESC_TAP_256  = 7;
	localparam int PRESC_TAP_1024 = 9;

endpackage

`default_nettype wire

/* rtl/io_bus_ctrl.sv */
// I/O bus control.
// Decodes the 6-bit I/O address into block selects and register
// offsets, qualifies the write strobe and returns read data.

`timescale 1ns/100ps
`default_nettype none

module io_bus_ctrl
(
	input  logic                  clk,
	input  logic                  rst,
	input  avr_io_pkg::io_addr_t  io_addr,
	input  logic                  io_wr,
	input  logic                  io_rd,
	input  avr_io_pkg::io_data_t  io_wdata,
	input  avr_io_pkg::io_data_t  rdata_b,
	input  avr_io_pkg::io_data_t  rdata_d,
	input  avr_io_pkg::io_data_t  rdata_tmr,
	output avr_io_pkg::io_data_t  io_rdata,
	output logic                  wr,
	output avr_io_pkg::io_data_t  wdata,
	output logic                  gpio_b_sel,
	output logic                  gpio_d_sel,
	output avr_io_pkg::gpio_reg_t gpio_reg,
	output logic                  tmr_sel,
	output avr_io_pkg::tmr_reg_t  tmr_reg
);

	import avr_io_pkg::*;

	// GPIO ports share one offset decode.
	always_comb
	begin
		gpio_b_sel = (io_addr inside {PINB_ADDR, DDRB_ADDR, PORTB_ADDR});
		gpio_d_sel = (io_addr inside {PIND_ADDR, DDRD_ADDR, PORTD_ADDR});
		case (io_addr)
			PINB_ADDR, PIND_ADDR:   gpio_reg = GPIO_PIN;
			DDRB_ADDR, DDRD_ADDR:   gpio_reg = GPIO_DDR;
			PORTB_ADDR, PORTD_ADDR: gpio_reg = GPIO_PORT;
			default:                gpio_reg = GPIO_PIN;
		endcase
	end

	// Timer 0 register decode.
	always_comb
	begin
		tmr_sel = 1'b1;
		case (io_addr)
			TIFR0_ADDR:  tmr_reg = TMR_TIFR;
			TCCR0A_ADDR: tmr_reg = TMR_TCCRA;
			TCCR0B_ADDR: tmr_reg = TMR_TCCRB;
			TCNT0_ADDR:  tmr_reg = TMR_TCNT;
			OCR0A_ADDR:  tmr_reg = TMR_OCRA;
			OCR0B_ADDR:  tmr_reg = TMR_OCRB;
			default:
			begin
				tmr_sel = 1'b0;
				tmr_reg = TMR_TIFR;
			end
		endcase
	end

	// Writes to unmapped addresses are dropped here.
	assign wr    = io_wr & (gpio_b_sel | gpio_d_sel | tmr_sel);
	assign wdata = io_wdata;

	// OR of the selected block's read value, zero outside a read.
	assign io_rdata = io_rd ? (({8{gpio_b_sel}} & rdata_b) |
	                           ({8{gpio_d_sel}} & rdata_d) |
	                           ({8{tmr_sel}} & rdata_tmr)) : '0;

	assert property (@(posedge clk) disable iff (rst)
		$onehot0({gpio_b_sel, gpio_d_sel, tmr_sel}))
		else $error("io_bus_ctrl: more than one block selected");

	assert property (@(posedge clk) disable iff (rst) !(io_wr && io_rd))
		else $error("io_bus_ctrl: io_wr and io_rd high together");

endmodule

`default_nettype wire

/* rtl/gpio_port.sv */
// GPIO port.
// PORT, DDR and PIN registers limited to the implemented pins, a
// two-flop input synchronizer and a per-pin alternate function that
// takes over both the output value and the output enable.

`timescale 1ns/100ps
`default_nettype none

module gpio_port
#(
	parameter avr_io_pkg::pins_t PIN_MASK = 8'hFF
)
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  sel,
	input  logic                  wr,
	input  avr_io_pkg::gpio_reg_t rd_reg,
	input  avr_io_pkg::io_data_t  wdata,
	input  avr_io_pkg::pins_t     pins_in,
	input  avr_io_pkg::pins_t     alt_en,
	input  avr_io_pkg::pins_t     alt_val,
	output avr_io_pkg::io_data_t  rdata,
	output avr_io_pkg::pins_t     pins_out,
	output avr_io_pkg::pins_t     pins_oe
);

	import avr_io_pkg::*;

	pins_t port_q;
	pins_t ddr_q;
	pins_t sync_meta;
	pins_t sync_q;

	// Register writes. A 1 written to PIN flips the PORT bit.
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			port_q <= '0;
			ddr_q  <= '0;
		end
		else if (sel && wr)
		begin
			case (rd_reg)
				GPIO_PIN:  port_q <= (port_q ^ pins_t'(wdata)) & PIN_MASK;
				GPIO_DDR:  ddr_q  <= pins_t'(wdata) & PIN_MASK;
				GPIO_PORT: port_q <= pins_t'(wdata) & PIN_MASK;
				default:   port_q <= port_q;
			endcase
		end
	end

	// Input synchronizer.
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			sync_meta <= '0;
			sync_q    <= '0;
		end
		else
		begin
			sync_meta <= pins_in;
			sync_q    <= sync_meta;
		end
	end

	always_comb
	begin
		case (rd_reg)
			GPIO_PIN:  rdata = io_data_t'(sync_q & PIN_MASK);
			GPIO_DDR:  rdata = io_data_t'(ddr_q);
			GPIO_PORT: rdata = io_data_t'(port_q);
			default:   rdata = '0;
		endcase
	end

	// Alternate function wins per pin.
	assign pins_out = (alt_en & alt_val) | (~alt_en & port_q);
	assign pins_oe  = alt_en | ddr_q;

	// The alternate enable comes from outside, so check the whole enable.
	assert property (@(posedge clk) disable iff (rst) (pins_oe & ~PIN_MASK) == '0)
		else $error("gpio_port: output enabled on an unimplemented pin");

endmodule

`default_nettype wire

/* rtl/timer_prescaler.sv */
// Timer prescaler.
// Free-running counter that decodes single-cycle tick enables for
// the divide-by-8, 64, 256 and 1024 timer clock selects.

`timescale 1ns/100ps
`default_nettype none

module timer_prescaler
(
	input  logic clk,
	input  logic rst,
	output logic tick_8,
	output logic tick_64,
	output logic tick_256,
	output logic tick_1024
);

	import avr_io_pkg::*;

	logic [PRESC_WIDTH-1:0] cnt;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	// A tick fires when every bit up to its tap is set.
	assign tick_8    = &cnt[PRESC_TAP_8:0];
	assign tick_64   = &cnt[PRESC_TAP_64:0];
	assign tick_256  = &cnt[PRESC_TAP_256:0];
	assign tick_1024 = &cnt[PRESC_TAP_1024:0];

endmodule

`default_nettype wire

/* rtl/timer0_8bit.sv */
// Timer 0, 8-bit, normal mode.
// Counts on the selected tick, raises overflow and compare flags,
// and toggles the OC0A and OC0B outputs on compare match.

`timescale 1ns/100ps
`default_nettype none

module timer0_8bit
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 sel,
	input  logic                 wr,
	input  avr_io_pkg::tmr_reg_t reg_sel,
	input  avr_io_pkg::io_data_t wdata,
	input  logic                 tick_8,
	input  logic                 tick_64,
	input  logic                 tick_256,
	input  logic                 tick_1024,
	output avr_io_pkg::io_data_t rdata,
	output logic                 irq_tov0,
	output logic                 irq_ocf0a,
	output logic                 irq_ocf0b,
	output logic                 oc0a,
	output logic                 oc0a_en,
	output logic                 oc0b,
	output logic                 oc0b_en
);

	import avr_io_pkg::*;

	logic [1:0] com0a;
	logic [1:0] com0b;
	clk_sel_t   cs;
	tmr_count_t tcnt0;
	tmr_count_t ocr0a;
	tmr_count_t ocr0b;
	logic       tov0;
	logic       ocf0a;
	logic       ocf0b;
	logic       oc0a_q;
	logic       oc0b_q;
	logic       tick;
	logic       wr_en;
	logic       count_en;
	logic       ovf_set;
	logic       cmpa_set;
	logic       cmpb_set;
	io_data_t   flag_clr;

	// Clock select. 0, 6 and 7 stop the counter.
	always_comb
	begin
		case (cs)
			3'd1:    tick = 1'b1;
			3'd2:    tick = tick_8;
			3'd3:    tick = tick_64;
			3'd4:    tick = tick_256;
			3'd5:    tick = tick_1024;
			default: tick = 1'b0;
		endcase
	end

	assign wr_en    = sel & wr;
	// A bus write to TCNT0 takes the place of the count.
	assign count_en = tick & ~(wr_en && reg_sel == TMR_TCNT);
	assign ovf_set  = count_en && (tcnt0 == 8'hFF);
	assign cmpa_set = count_en && (tcnt0 == ocr0a);
	assign cmpb_set = count_en && (tcnt0 == ocr0b);
	assign flag_clr = (wr_en && reg_sel == TMR_TIFR) ? wdata : '0;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			com0a <= '0;
			com0b <= '0;
			cs    <= '0;
			ocr0a <= '0;
			ocr0b <= '0;
		end
		else if (wr_en)
		begin
			case (reg_sel)
				TMR_TCCRA:
				begin
					com0a <= wdata[COM0A_LSB +: 2];
					com0b <= wdata[COM0B_LSB +: 2];
				end
				TMR_TCCRB: cs    <= clk_sel_t'(wdata[2:0]);
				TMR_OCRA:  ocr0a <= tmr_count_t'(wdata);
				TMR_OCRB:  ocr0b <= tmr_count_t'(wdata);
				default:   cs    <= cs;
			endcase
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			tcnt0 <= '0;
		else if (wr_en && reg_sel == TMR_TCNT)
			tcnt0 <= tmr_count_t'(wdata);
		else if (count_en)
			tcnt0 <= tcnt0 + 1'b1;
	end

	// Flags. Setting wins over a write-one clear.
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			tov0  <= 1'b0;
			ocf0a <= 1'b0;
			ocf0b <= 1'b0;
		end
		else
		begin
			tov0  <= ovf_set | (tov0 & ~flag_clr[TOV0_BIT]);
			ocf0a <= cmpa_set | (ocf0a & ~flag_clr[OCF0A_BIT]);
			ocf0b <= cmpb_set | (ocf0b & ~flag_clr[OCF0B_BIT]);
		end
	end

	// Compare outputs, toggled on match.
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			oc0a_q <= 1'b0;
			oc0b_q <= 1'b0;
		end
		else
		begin
			if (cmpa_set && oc0a_en)
				oc0a_q <= ~oc0a_q;
			if (cmpb_set && oc0b_en)
				oc0b_q <= ~oc0b_q;
		end
	end

	always_comb
	begin
		rdata = '0;
		case (reg_sel)
			TMR_TIFR:
			begin
				rdata[TOV0_BIT]  = tov0;
				rdata[OCF0A_BIT] = ocf0a;
				rdata[OCF0B_BIT] = ocf0b;
			end
			TMR_TCCRA:
			begin
				rdata[COM0A_LSB +: 2] = com0a;
				rdata[COM0B_LSB +: 2] = com0b;
			end
			TMR_TCCRB: rdata[2:0] = cs;
			TMR_TCNT:  rdata = io_data_t'(tcnt0);
			TMR_OCRA:  rdata = io_data_t'(ocr0a);
			TMR_OCRB:  rdata = io_data_t'(ocr0b);
			default:   rdata = '0;
		endcase
	end

	assign irq_tov0  = tov0;
	assign irq_ocf0a = ocf0a;
	assign irq_ocf0b = ocf0b;
	assign oc0a      = oc0a_q;
	assign oc0b      = oc0b_q;
	assign oc0a_en   = (com0a == COM_TOGGLE);
	assign oc0b_en   = (com0b == COM_TOGGLE);

	assert property (@(posedge clk) disable iff (rst) ovf_set |=> tov0)
		else $error("timer0_8bit: TOV0 lost on overflow");
	assert property (@(posedge clk) disable iff (rst) cmpa_set |=> ocf0a)
		else $error("timer0_8bit: OCF0A lost on compare match");
	assert property (@(posedge clk) disable iff (rst) cmpb_set |=> ocf0b)
		else $error("timer0_8bit: OCF0B lost on compare match");

endmodule

`default_nettype wire

/* rtl/avr_io_top.sv */
// AVR I/O subsystem top level.
// Connects the I/O bus control to GPIO ports B and D, the timer
// prescaler and timer 0. OC0A drives PB7 and OC0B drives PD0.

`timescale 1ns/100ps
`default_nettype none

module avr_io_top
(
	input  logic                 clk,
	input  logic                 rst,
	input  avr_io_pkg::io_addr_t io_addr,
	input  avr_io_pkg::io_data_t io_wdata,
	input  logic                 io_wr,
	input  logic                 io_rd,
	input  avr_io_pkg::pins_t    pb_in,
	input  avr_io_pkg::pins_t    pd_in,
	output avr_io_pkg::io_data_t io_rdata,
	output avr_io_pkg::pins_t    pb_out,
	output avr_io_pkg::pins_t    pb_oe,
	output avr_io_pkg::pins_t    pd_out,
	output avr_io_pkg::pins_t    pd_oe,
	output logic                 irq_tov0,
	output logic                 irq_ocf0a,
	output logic                 irq_ocf0b
);

	import avr_io_pkg::*;

	io_data_t  rdata_b;
	io_data_t  rdata_d;
	io_data_t  rdata_tmr;
	io_data_t  wdata;
	logic      wr;
	logic      gpio_b_sel;
	logic      gpio_d_sel;
	gpio_reg_t gpio_reg;
	logic      tmr_sel;
	tmr_reg_t  tmr_reg;
	logic      tick_8;
	logic      tick_64;
	logic      tick_256;
	logic      tick_1024;
	logic      oc0a;
	logic      oc0a_en;
	logic      oc0b;
	logic      oc0b_en;

	io_bus_ctrl bus_ctrl
	(
		.clk        (clk),
		.rst        (rst),
		.io_addr    (io_addr),
		.io_wr      (io_wr),
		.io_rd      (io_rd),
		.io_wdata   (io_wdata),
		.rdata_b    (rdata_b),
		.rdata_d    (rdata_d),
		.rdata_tmr  (rdata_tmr),
		.io_rdata   (io_rdata),
		.wr         (wr),
		.wdata      (wdata),
		.gpio_b_sel (gpio_b_sel),
		.gpio_d_sel (gpio_d_sel),
		.gpio_reg   (gpio_reg),
		.tmr_sel    (tmr_sel),
		.tmr_reg    (tmr_reg)
	);

	gpio_port #(.PIN_MASK(PORTB_PIN_MASK)) port_b
	(
		.clk      (clk),
		.rst      (rst),
		.sel      (gpio_b_sel),
		.wr       (wr),
		.rd_reg   (gpio_reg),
		.wdata    (wdata),
		.pins_in  (pb_in),
		.alt_en   (pins_t'(oc0a_en) << OC0A_PIN),
		.alt_val  (pins_t'(oc0a) << OC0A_PIN),
		.rdata    (rdata_b),
		.pins_out (pb_out),
		.pins_oe  (pb_oe)
	);

	gpio_port #(.PIN_MASK(PORTD_PIN_MASK)) port_d
	(
		.clk      (clk),
		.rst      (rst),
		.sel      (gpio_d_sel),
		.wr       (wr),
		.rd_reg   (gpio_reg),
		.wdata    (wdata),
		.pins_in  (pd_in),
		.alt_en   (pins_t'(oc0b_en) << OC0B_PIN),
		.alt_val  (pins_t'(oc0b) << OC0B_PIN),
		.rdata    (rdata_d),
		.pins_out (pd_out),
		.pins_oe  (pd_oe)
	);

	timer_prescaler prescaler
	(
		.clk       (clk),
		.rst       (rst),
		.tick_8    (tick_8),
		.tick_64   (tick_64),
		.tick_256  (tick_256),
		.tick_1024 (tick_1024)
	);

	timer0_8bit timer0
	(
		.clk       (clk),
		.rst       (rst),
		.sel       (tmr_sel),
		.wr        (wr),
		.reg_sel   (tmr_reg),
		.wdata     (wdata),
		.tick_8    (tick_8),
		.tick_64   (tick_64),
		.tick_256  (tick_256),
		.tick_1024 (tick_1024),
		.rdata     (rdata_tmr),
		.irq_tov0  (irq_tov0),
		.irq_ocf0a (irq_ocf0a),
		.irq_ocf0b (irq_ocf0b),
		.oc0a      (oc0a),
		.oc0a_en   (oc0a_en),
		.oc0b      (oc0b),
		.oc0b_en   (oc0b_en)
	);

endmodule

`default_nettype wire

/* verification/tb_avr_io_tasks.svh */
// Bus access tasks and directed tests for the AVR I/O testbench.
// Included in the testbench module body.

`ifndef TB_AVR_IO_TASKS_SVH
`define TB_AVR_IO_TASKS_SVH

	// The write lands at the second rising edge.
	task automatic io_write(input io_addr_t addr, input io_data_t data);
		@(posedge clk);
		io_addr  <= addr;
		io_wdata <= data;
		io_wr    <= 1'b1;
		@(posedge clk);
		io_wr <= 1'b0;
	endtask

	// Read data is taken mid-cycle, at the falling edge.
	task automatic io_read(input io_addr_t addr, output io_data_t data);
		@(posedge clk);
		io_addr <= addr;
		io_rd   <= 1'b1;
		@(negedge clk);
		data = io_rdata;
		@(posedge clk);
		io_rd <= 1'b0;
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst <= 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
	endtask

	// Interrupt lines packed in TIFR0 bit order.
	function automatic logic [2:0] irq_flags();
		logic [2:0] flags;
		flags            = '0;
		flags[TOV0_BIT]  = irq_tov0;
		flags[OCF0A_BIT] = irq_ocf0a;
		flags[OCF0B_BIT] = irq_ocf0b;
		return flags;
	endfunction

	// Counts rising edges until the flags are up, looking at each falling edge.
	task automatic wait_flags(input string name, input logic [2:0] mask, input int limit,
		output int cycles);
		cycles = 0;
		do
		begin
			@(posedge clk);
			cycles++;
			@(negedge clk);
		end
		while (cycles < limit && (irq_flags() & mask) != mask);
		if ((irq_flags() & mask) != mask)
		begin
			error_count++;
			$display("%s: interrupt flags %b did not rise within %0d cycles", name, mask, limit);
		end
	endtask

	task automatic reset_state();
		io_addr_t regs [12];
		io_data_t data;
		regs = '{PINB_ADDR, DDRB_ADDR, PORTB_ADDR, PIND_ADDR, DDRD_ADDR, PORTD_ADDR,
			TIFR0_ADDR, TCCR0A_ADDR, TCCR0B_ADDR, TCNT0_ADDR, OCR0A_ADDR, OCR0B_ADDR};
		@(negedge clk);
		check_pins("reset pb_oe", '0, pb_oe);
		check_pins("reset pd_oe", '0, pd_oe);
		check_pins("reset irq lines", '0, pins_t'(irq_flags()));
		check_data("reset idle rdata", '0, io_rdata);
		foreach (regs[i])
		begin
			io_read(regs[i], data);
			check_data($sformatf("reset read %h", regs[i]), '0, data);
		end
	endtask

	task automatic gpio_output();
		io_data_t ddr_b, port_b, ddr_d, port_d, data;
		random_byte(ddr_b);
		random_byte(port_b);
		random_byte(ddr_d);
		random_byte(port_d);
		io_write(DDRB_ADDR, ddr_b);
		io_write(PORTB_ADDR, port_b);
		io_write(DDRD_ADDR, ddr_d);
		io_write(PORTD_ADDR, port_d);
		io_read(DDRB_ADDR, data);
		check_data("gpio ddrb", ddr_b & PORTB_PIN_MASK, data);
		io_read(PORTB_ADDR, data);
		check_data("gpio portb", port_b & PORTB_PIN_MASK, data);
		io_read(DDRD_ADDR, data);
		check_data("gpio ddrd", ddr_d & PORTD_PIN_MASK, data);
		io_read(PORTD_ADDR, data);
		check_data("gpio portd", port_d & PORTD_PIN_MASK, data);
		@(negedge clk);
		check_pins("gpio pb_out", port_b & PORTB_PIN_MASK, pb_out);
		check_pins("gpio pb_oe", ddr_b & PORTB_PIN_MASK, pb_oe);
		check_pins("gpio pd_out", port_d & PORTD_PIN_MASK, pd_out);
		check_pins("gpio pd_oe", ddr_d & PORTD_PIN_MASK, pd_oe);
	endtask

	task automatic gpio_input_toggle();
		io_data_t pin_val, port_val, toggle, data;
		random_byte(pin_val);
		@(posedge clk);
		pd_in <= pin_val;
		pb_in <= ~pin_val;
		// Two synchronizer flops sit between the pins and PIN.
		repeat (2) @(posedge clk);
		io_read(PIND_ADDR, data);
		check_data("input pind", pin_val & PORTD_PIN_MASK, data);
		io_read(PINB_ADDR, data);
		check_data("input pinb", ~pin_val & PORTB_PIN_MASK, data);
		random_byte(port_val);
		random_byte(toggle);
		io_write(PORTB_ADDR, port_val);
		io_write(PINB_ADDR, toggle);
		io_read(PORTB_ADDR, data);
		check_data("toggle portb", (port_val ^ toggle) & PORTB_PIN_MASK, data);
	endtask

	task automatic timer_overflow();
		io_data_t data;
		int       cycles;
		apply_reset();
		io_write(TCNT0_ADDR, 8'd250);
		io_write(TCCR0B_ADDR, 8'd1);
		wait_flags("overflow", 3'(1 << TOV0_BIT), 20, cycles);
		check_cycles("overflow latency", 6, cycles);
		// One more tick has passed since the wrap when the read is taken.
		io_read(TCNT0_ADDR, data);
		check_data("overflow tcnt0", 8'd1, data);
		io_write(TCCR0B_ADDR, 8'd0);
		io_write(TIFR0_ADDR, io_data_t'(1 << TOV0_BIT));
		@(negedge clk);
		check_bit("overflow irq cleared", 1'b0, irq_tov0);
		io_read(TIFR0_ADDR, data);
		check_bit("overflow tov0 cleared", 1'b0, data[TOV0_BIT]);
	endtask

	task automatic compare_toggle();
		io_data_t data;
		int       cycles;
		apply_reset();
		io_write(OCR0A_ADDR, 8'd20);
		io_write(OCR0B_ADDR, 8'd40);
		io_write(TCCR0A_ADDR, (io_data_t'(COM_TOGGLE) << COM0A_LSB) |
			(io_data_t'(COM_TOGGLE) << COM0B_LSB));
		@(negedge clk);
		check_pins("compare pb_oe", pins_t'(1) << OC0A_PIN, pb_oe);
		check_pins("compare pd_oe", pins_t'(1) << OC0B_PIN, pd_oe);
		check_bit("compare pb7 start", 1'b0, pb_out[OC0A_PIN]);
		check_bit("compare pd0 start", 1'b0, pd_out[OC0B_PIN]);
		io_write(TCCR0B_ADDR, 8'd1);
		// Match on the tick taken while TCNT0 equals OCR0A, 21 ticks from 0.
		wait_flags("compare a", 3'(1 << OCF0A_BIT), 100, cycles);
		check_cycles("compare a latency", 21, cycles);
		check_bit("compare pb7 toggled", 1'b1, pb_out[OC0A_PIN]);
		check_bit("compare pd0 held", 1'b0, pd_out[OC0B_PIN]);
		wait_flags("compare b", 3'(1 << OCF0B_BIT), 100, cycles);
		check_cycles("compare b latency", 40 - 20, cycles);
		check_bit("compare pd0 toggled", 1'b1, pd_out[OC0B_PIN]);
		io_read(TIFR0_ADDR, data);
		check_data("compare tifr0", io_data_t'((1 << OCF0A_BIT) | (1 << OCF0B_BIT)), data);
	endtask

	task automatic prescaled_count();
		io_data_t data;
		io_data_t frozen;
		apply_reset();
		io_write(TCCR0B_ADDR, 8'd2);
		repeat (85) @(posedge clk);
		io_read(TCNT0_ADDR, data);
		check_range("prescale tcnt0", 8'd10, 8'd11, data);
		io_write(TCCR0B_ADDR, 8'd0);
		io_read(TCNT0_ADDR, frozen);
		repeat (50) @(posedge clk);
		io_read(TCNT0_ADDR, data);
		check_data("prescale frozen", frozen, data);
	endtask

`endif

/* verification/tb_avr_io.sv */
// Testbench for the AVR I/O subsystem.
// Drives the I/O bus and the port pins of avr_io_top, runs the
// directed tests and prints a summary of the checks.

`timescale 1ns/100ps
`default_nettype none

module tb_avr_io;

	import avr_io_pkg::*;

	// The test sequence takes well under a thousand cycles.
	localparam int TIMEOUT_CYCLES = 20000;

	logic        clk;
	logic        rst;
	io_addr_t    io_addr;
	io_data_t    io_wdata;
	logic        io_wr;
	logic        io_rd;
	pins_t       pb_in;
	pins_t       pd_in;
	io_data_t    io_rdata;
	pins_t       pb_out;
	pins_t       pb_oe;
	pins_t       pd_out;
	pins_t       pd_oe;
	logic        irq_tov0;
	logic        irq_ocf0a;
	logic        irq_ocf0b;
	logic [31:0] lfsr_state;
	int          cycle_count;
	int          check_count;
	int          error_count;

	avr_io_top avr_io_top_inst
	(
		.clk       (clk),
		.rst       (rst),
		.io_addr   (io_addr),
		.io_wdata  (io_wdata),
		.io_wr     (io_wr),
		.io_rd     (io_rd),
		.pb_in     (pb_in),
		.pd_in     (pd_in),
		.io_rdata  (io_rdata),
		.pb_out    (pb_out),
		.pb_oe     (pb_oe),
		.pd_out    (pd_out),
		.pd_oe     (pd_oe),
		.irq_tov0  (irq_tov0),
		.irq_ocf0a (irq_ocf0a),
		.irq_ocf0b (irq_ocf0b)
	);

	// 40 ns clock period.
	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Simulation timed out after %0d cycles", cycle_count);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// Fibonacci LFSR, taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic random_byte(output io_data_t value);
		for (int i = 0; i < 8; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			value[i]   = lfsr_state[0];
		end
	endtask

	task automatic check_data(input string name, input io_data_t expected,
		input io_data_t actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("ERR %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_pins(input string name, input pins_t expected, input pins_t actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("ERR %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("ERR %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic check_range(input string name, input tmr_count_t low,
		input tmr_count_t high, input tmr_count_t actual);
		check_count++;
		if (actual < low || actual > high)
		begin
			error_count++;
			$display("ERR %s: expected %0d to %0d, actual %0d", name, low, high, actual);
		end
	endtask

	task automatic check_cycles(input string name, input int expected, input int actual);
		check_count++;
		if (actual != expected)
		begin
			error_count++;
			$display("ERR %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	`include "tb_avr_io_tasks.svh"

	initial
	begin
		clk         = 1'b0;
		rst         = 1'b1;
		io_addr     = '0;
		io_wdata    = '0;
		io_wr       = 1'b0;
		io_rd       = 1'b0;
		pb_in       = '0;
		pd_in       = '0;
		cycle_count = 0;
		check_count = 0;
		error_count = 0;
		lfsr_state  = 32'h6e68b3ce;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		reset_state();
		gpio_output();
		gpio_input_toggle();
		timer_overflow();
		compare_toggle();
		prescaled_count();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+verification
rtl/avr_io_pkg.sv
rtl/io_bus_ctrl.sv
rtl/gpio_port.sv
rtl/timer_prescaler.sv
rtl/timer0_8bit.sv
rtl/avr_io_top.sv
verification/tb_avr_io.sv

/* Makefile */
# Verilator build and run of the AVR I/O testbench.

SRCS := $(wildcard rtl/*.sv verification/*.sv verification/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
obj_dir/Vtb_avr_io: sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_avr_io \
		-f sim.f -Mdir obj_dir

run: obj_dir/Vtb_avr_io
	./obj_dir/Vtb_avr_io | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
